// ==== rtl/pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Entries in the queue between the two decode stages
`define DE_FIFO_DEPTH 2

// EIP after reset
`define RESET_EIP 32'h0000_1000

// General registers EAX..EDI
`define GPR_COUNT 8

`endif

// ==== rtl/x86_isa_pkg.sv ====
package x86_isa_pkg;

   // Supported one-byte opcodes
   localparam logic [7:0] OP_ADD_RM_R   = 8'h01;
   localparam logic [7:0] OP_ADD_R_RM   = 8'h03;
   localparam logic [7:0] OP_MOV_RM_R   = 8'h89;
   localparam logic [7:0] OP_MOV_R_RM   = 8'h8B;
   localparam logic [7:0] OP_GRP1_IMM32 = 8'h81;
   localparam logic [7:0] OP_GRP1_IMM8  = 8'h83;
   // B8..BF share the upper five bits, register in the low three
   localparam logic [4:0] OP_MOV_R_IMM_HI = 5'b10111;

   // Prefix bytes
   localparam logic [7:0] PFX_OPSIZE = 8'h66;
   localparam logic [7:0] PFX_ES     = 8'h26;
   localparam logic [7:0] PFX_CS     = 8'h2E;
   localparam logic [7:0] PFX_SS     = 8'h36;
   localparam logic [7:0] PFX_DS     = 8'h3E;
   localparam logic [7:0] PFX_FS     = 8'h64;
   localparam logic [7:0] PFX_GS     = 8'h65;

   // 32-bit addressing encodings
   localparam logic [1:0] MOD_NODISP    = 2'b00;
   localparam logic [1:0] MOD_DISP8     = 2'b01;
   localparam logic [1:0] MOD_DISP32    = 2'b10;
   localparam logic [1:0] MOD_REG       = 2'b11;
   localparam logic [2:0] RM_SIB        = 3'b100;
   localparam logic [2:0] RM_DISP32     = 3'b101;
   localparam logic [2:0] SIB_NO_INDEX  = 3'b100;
   localparam logic [2:0] SIB_BASE_NONE = 3'b101;

   typedef struct packed {
      logic [1:0] mod;
      logic [2:0] reg_op;
      logic [2:0] rm;
   } modrm_t;

   typedef struct packed {
      logic [1:0] scale;
      logic [2:0] index;
      logic [2:0] base;
   } sib_t;

   // One address byte, seen either as ModR/M or as SIB
   typedef union packed {
      modrm_t     modrm;
      sib_t       sib;
      logic [7:0] raw;
   } addr_byte_u;

   typedef enum logic [2:0] {
      SEG_ES = 3'd0,
      SEG_CS = 3'd1,
      SEG_SS = 3'd2,
      SEG_DS = 3'd3,
      SEG_FS = 3'd4,
      SEG_GS = 3'd5
   } seg_id_t;

endpackage

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

   // Decode stage 1 result, raw fields as found in the byte window
   typedef struct packed {
      logic [7:0]              opcode;
      x86_isa_pkg::addr_byte_u modrm;
      x86_isa_pkg::addr_byte_u sib;
      logic                    modrm_pres;
      logic                    sib_pres;
      logic                    disp_pres;
      logic [2:0]              disp_size;   // bytes: 0, 1 or 4
      logic [2:0]              imm_size;    // bytes: 0, 1, 2 or 4
      logic [31:0]             disp;
      logic [31:0]             imm;
      x86_isa_pkg::seg_id_t    seg;
      logic                    op16;
      logic [3:0]              length;
      logic                    invalid;
   } de_fields_t;

   // Decode stage 2 result, ready for address generation
   typedef struct packed {
      logic [31:0]          eip;
      logic [7:0]           opcode;
      logic [3:0]           length;
      logic                 mem;
      logic [31:0]          ea;
      logic [31:0]          imm;
      logic [2:0]           reg_id;
      x86_isa_pkg::seg_id_t seg;
      logic                 op16;
      logic                 invalid;
   } ag_out_t;

endpackage

// ==== rtl/decode_stage1.sv ====
`timescale 1ns/1ps

module decode_stage1 (
   input  logic [127:0]         ir,
   output pipe_pkg::de_fields_t fields
);

   logic [1:0]              n_pfx;
   logic                    scan;
   logic [7:0]              pb;
   logic                    op16;
   x86_isa_pkg::seg_id_t    seg;
   logic [7:0]              opcode;
   x86_isa_pkg::addr_byte_u modrm;
   x86_isa_pkg::addr_byte_u sib;
   logic                    modrm_pres;
   logic                    sib_pres;
   logic                    invalid;
   logic [2:0]              disp_size;
   logic [2:0]              imm_size;
   logic [3:0]              disp_start;
   logic [3:0]              imm_start;

   // Byte 0 of the window sits in the top bits
   function automatic logic [7:0] byte_at(input logic [127:0] win, input logic [3:0] idx);
      return win[8 * (15 - idx) +: 8];
   endfunction

   // Little-endian field of size bytes, upper bytes zero
   function automatic logic [31:0] take_le(input logic [127:0] win, input logic [3:0] start,
                                           input logic [2:0] size);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < 4; k++) begin
         if (k < size)
            v[8 * k +: 8] = byte_at(win, start + 4'(k));
      end
      return v;
   endfunction

   // Prefix scan, stops at the first non-prefix byte
   always_comb begin
      n_pfx = 2'd0;
      scan  = 1'b1;
      op16  = 1'b0;
      seg   = x86_isa_pkg::SEG_DS;
      for (int i = 0; i < 3; i++) begin
         pb = byte_at(ir, 4'(i));
         if (scan) begin
            case (pb)
               x86_isa_pkg::PFX_OPSIZE: op16 = 1'b1;
               x86_isa_pkg::PFX_ES:     seg  = x86_isa_pkg::SEG_ES;
               x86_isa_pkg::PFX_CS:     seg  = x86_isa_pkg::SEG_CS;
               x86_isa_pkg::PFX_SS:     seg  = x86_isa_pkg::SEG_SS;
               x86_isa_pkg::PFX_DS:     seg  = x86_isa_pkg::SEG_DS;
               x86_isa_pkg::PFX_FS:     seg  = x86_isa_pkg::SEG_FS;
               x86_isa_pkg::PFX_GS:     seg  = x86_isa_pkg::SEG_GS;
               default:                 scan = 1'b0;
            endcase
            if (scan)
               n_pfx = n_pfx + 2'd1;
         end
      end
   end

   always_comb begin
      opcode     = byte_at(ir, {2'b00, n_pfx});
      modrm.raw  = byte_at(ir, {2'b00, n_pfx} + 4'd1);
      sib.raw    = byte_at(ir, {2'b00, n_pfx} + 4'd2);
      modrm_pres = 1'b1;
      imm_size   = 3'd0;
      invalid    = 1'b0;
      case (opcode)
         x86_isa_pkg::OP_ADD_RM_R,
         x86_isa_pkg::OP_ADD_R_RM,
         x86_isa_pkg::OP_MOV_RM_R,
         x86_isa_pkg::OP_MOV_R_RM:   imm_size = 3'd0;
         x86_isa_pkg::OP_GRP1_IMM32: imm_size = op16 ? 3'd2 : 3'd4;
         x86_isa_pkg::OP_GRP1_IMM8:  imm_size = 3'd1;
         default: begin
            modrm_pres = 1'b0;
            if (opcode[7:3] == x86_isa_pkg::OP_MOV_R_IMM_HI)
               imm_size = op16 ? 3'd2 : 3'd4;
            else
               invalid = 1'b1;
         end
      endcase

      sib_pres = modrm_pres && (modrm.modrm.mod != x86_isa_pkg::MOD_REG) &&
                 (modrm.modrm.rm == x86_isa_pkg::RM_SIB);

      disp_size = 3'd0;
      if (modrm_pres) begin
         case (modrm.modrm.mod)
            x86_isa_pkg::MOD_NODISP: begin
               // disp32 with no base, either directly or through SIB
               if ((!sib_pres && modrm.modrm.rm == x86_isa_pkg::RM_DISP32) ||
                   (sib_pres && sib.sib.base == x86_isa_pkg::SIB_BASE_NONE))
                  disp_size = 3'd4;
            end
            x86_isa_pkg::MOD_DISP8:  disp_size = 3'd1;
            x86_isa_pkg::MOD_DISP32: disp_size = 3'd4;
            default:                 disp_size = 3'd0;
         endcase
      end

      disp_start = {2'b00, n_pfx} + 4'd1 + {3'b000, modrm_pres} + {3'b000, sib_pres};
      imm_start  = disp_start + {1'b0, disp_size};
   end

   always_comb begin
      fields.opcode     = opcode;
      fields.modrm      = modrm;
      fields.sib        = sib;
      fields.modrm_pres = modrm_pres;
      fields.sib_pres   = sib_pres;
      fields.disp_pres  = (disp_size != 3'd0);
      fields.disp_size  = disp_size;
      fields.imm_size   = imm_size;
      fields.disp       = take_le(ir, disp_start, disp_size);
      fields.imm        = take_le(ir, imm_start, imm_size);
      fields.seg        = seg;
      fields.op16       = op16;
      // Invalid opcodes end right after the opcode byte
      fields.length     = imm_start + {1'b0, imm_size};
      fields.invalid    = invalid;
   end

endmodule

// ==== rtl/de_latch_fifo.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module de_latch_fifo (
   input  logic                 CLK,
   input  logic                 rst,
   input  logic                 in_valid,
   input  pipe_pkg::de_fields_t in_fields,
   output logic                 in_ready,
   output logic                 out_valid,
   output pipe_pkg::de_fields_t out_fields,
   input  logic                 out_pop
);

   localparam int DEPTH = `DE_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   pipe_pkg::de_fields_t mem [DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;
   logic                 push;
   logic                 pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign out_valid  = (count != '0);
   assign out_fields = mem[rd_ptr];
   assign pop        = out_pop && out_valid;
   // Full queue still takes a word when one leaves in the same cycle
   assign in_ready   = (count != CNT_W'(DEPTH)) || pop;
   assign push       = in_valid && in_ready;

   always_ff @(posedge CLK) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (push)
         mem[wr_ptr] <= in_fields;
   end

endmodule

// ==== rtl/gpr_file.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module gpr_file (
   input  logic        CLK,
   input  logic        rst,
   input  logic [2:0]  rd_id_a,
   input  logic [2:0]  rd_id_b,
   output logic [31:0] rd_data_a,
   output logic [31:0] rd_data_b,
   input  logic        wr_en,
   input  logic [2:0]  wr_id,
   input  logic [31:0] wr_data
);

   logic [31:0] regs [`GPR_COUNT];

   // Reads see the value before a same-cycle write
   assign rd_data_a = regs[rd_id_a];
   assign rd_data_b = regs[rd_id_b];

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `GPR_COUNT; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_id] <= wr_data;
      end
   end

endmodule

// ==== rtl/decode_stage2.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_stage2 (
   input  logic                 CLK,
   input  logic                 rst,
   input  logic                 in_valid,
   input  pipe_pkg::de_fields_t in_fields,
   output logic                 in_pop,
   output logic [2:0]           rd_id_a,
   output logic [2:0]           rd_id_b,
   input  logic [31:0]          rd_data_a,
   input  logic [31:0]          rd_data_b,
   output pipe_pkg::ag_out_t    ag_out,
   output logic                 ag_valid,
   input  logic                 ag_ready
);

   x86_isa_pkg::modrm_t modrm;
   x86_isa_pkg::sib_t   sib;
   logic                load;
   logic                mem;
   logic                no_base;
   logic                has_index;
   logic [31:0]         base_val;
   logic [31:0]         index_val;
   logic [31:0]         disp_ext;
   logic [31:0]         imm_ext;
   logic [31:0]         eip;
   pipe_pkg::ag_out_t   ag_next;

   assign modrm = in_fields.modrm.modrm;
   assign sib   = in_fields.sib.sib;

   // Base from SIB when present, else rm
   assign rd_id_a = in_fields.sib_pres ? sib.base : modrm.rm;
   assign rd_id_b = sib.index;

   assign mem     = in_fields.modrm_pres && (modrm.mod != x86_isa_pkg::MOD_REG);
   assign no_base = (modrm.mod == x86_isa_pkg::MOD_NODISP) &&
                    (in_fields.sib_pres ? (sib.base == x86_isa_pkg::SIB_BASE_NONE)
                                        : (modrm.rm == x86_isa_pkg::RM_DISP32));
   assign has_index = in_fields.sib_pres && (sib.index != x86_isa_pkg::SIB_NO_INDEX);

   assign base_val  = (mem && !no_base) ? rd_data_a : 32'd0;
   assign index_val = has_index ? (rd_data_b << sib.scale) : 32'd0;

   always_comb begin
      case (in_fields.disp_size)
         3'd1:    disp_ext = {{24{in_fields.disp[7]}}, in_fields.disp[7:0]};
         3'd4:    disp_ext = in_fields.disp;
         default: disp_ext = 32'd0;
      endcase
      case (in_fields.imm_size)
         3'd1:    imm_ext = {{24{in_fields.imm[7]}}, in_fields.imm[7:0]};
         3'd2:    imm_ext = {{16{in_fields.imm[15]}}, in_fields.imm[15:0]};
         3'd4:    imm_ext = in_fields.imm;
         default: imm_ext = 32'd0;
      endcase
   end

   always_comb begin
      ag_next.eip     = eip;
      ag_next.opcode  = in_fields.opcode;
      ag_next.length  = in_fields.length;
      ag_next.mem     = mem;
      ag_next.ea      = base_val + index_val + disp_ext;
      ag_next.imm     = imm_ext;
      // B8..BF carry the register in the opcode
      ag_next.reg_id  = in_fields.modrm_pres ? modrm.reg_op : in_fields.opcode[2:0];
      ag_next.seg     = in_fields.seg;
      ag_next.op16    = in_fields.op16;
      ag_next.invalid = in_fields.invalid;
   end

   // Output register takes a new word when empty or being drained
   assign load   = !ag_valid || ag_ready;
   assign in_pop = in_valid && load;

   always_ff @(posedge CLK) begin
      if (rst) begin
         ag_valid <= 1'b0;
         eip      <= `RESET_EIP;
      end else begin
         if (load)
            ag_valid <= in_valid;
         if (in_pop)
            eip <= eip + {28'd0, in_fields.length};
      end
   end

   always_ff @(posedge CLK) begin
      if (in_pop)
         ag_out <= ag_next;
   end

endmodule

// ==== rtl/decode_pipeline.sv ====
`timescale 1ns/1ps

module decode_pipeline (
   input  logic              CLK,
   input  logic              rst,
   input  logic [127:0]      ir,
   input  logic              ir_valid,
   output logic              ir_ready,
   output pipe_pkg::ag_out_t ag_out,
   output logic              ag_valid,
   input  logic              ag_ready,
   input  logic              wb_we,
   input  logic [2:0]        wb_id,
   input  logic [31:0]       wb_data
);

   pipe_pkg::de_fields_t de_fields;
   pipe_pkg::de_fields_t q_fields;
   logic                 q_valid;
   logic                 q_pop;
   logic [2:0]           rd_id_a;
   logic [2:0]           rd_id_b;
   logic [31:0]          rd_data_a;
   logic [31:0]          rd_data_b;

   decode_stage1 u_decode_stage1 (
      .ir     (ir),
      .fields (de_fields)
   );

   // Latch queue between the decode stages
   de_latch_fifo u_de_latch_fifo (
      .CLK        (CLK),
      .rst        (rst),
      .in_valid   (ir_valid),
      .in_fields  (de_fields),
      .in_ready   (ir_ready),
      .out_valid  (q_valid),
      .out_fields (q_fields),
      .out_pop    (q_pop)
   );

   decode_stage2 u_decode_stage2 (
      .CLK       (CLK),
      .rst       (rst),
      .in_valid  (q_valid),
      .in_fields (q_fields),
      .in_pop    (q_pop),
      .rd_id_a   (rd_id_a),
      .rd_id_b   (rd_id_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .ag_out    (ag_out),
      .ag_valid  (ag_valid),
      .ag_ready  (ag_ready)
   );

   gpr_file u_gpr_file (
      .CLK       (CLK),
      .rst       (rst),
      .rd_id_a   (rd_id_a),
      .rd_id_b   (rd_id_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wb_we),
      .wr_id     (wb_id),
      .wr_data   (wb_data)
   );

endmodule

// ==== tb/decode_pipeline_assertions.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_pipeline_assertions (
   input logic              CLK,
   input logic              rst,
   input logic              hold_valid,
   input logic              hold_ready,
   input pipe_pkg::ag_out_t hold_data,
   input logic              push,
   input logic              pop,
   input logic              full,
   input logic              empty
);

   // Stalled output word stays put
   a_hold_stable: assert property (@(posedge CLK) disable iff (rst)
      hold_valid && !hold_ready |=> hold_valid && $stable(hold_data))
      else $error("output changed while stalled");

   // A full queue that takes a word stays exactly full
   a_no_overflow: assert property (@(posedge CLK) disable iff (rst) push && full |=> full)
      else $error("queue pushed while full");

   // Stage 2 asks for a word only when the queue holds one
   a_no_underflow: assert property (@(posedge CLK) disable iff (rst) pop |-> !empty)
      else $error("queue popped while empty");

   a_reset_idle: assert property (@(posedge CLK) rst |=> !hold_valid)
      else $error("output valid right after reset");

endmodule

bind decode_stage2 decode_pipeline_assertions u_stage2_assertions (
   .CLK        (CLK),
   .rst        (rst),
   .hold_valid (ag_valid),
   .hold_ready (ag_ready),
   .hold_data  (ag_out),
   .push       (1'b0),
   .pop        (1'b0),
   .full       (1'b0),
   .empty      (1'b0)
);

bind de_latch_fifo decode_pipeline_assertions u_fifo_assertions (
   .CLK        (CLK),
   .rst        (rst),
   .hold_valid (1'b0),
   .hold_ready (1'b1),
   .hold_data  ('0),
   .push       (push),
   .pop        (out_pop),
   .full       (count == `DE_FIFO_DEPTH),
   .empty      (count == '0)
);

// ==== tb/decode_pipeline_tb.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_pipeline_tb;

   localparam int NROWS = 17;

   typedef struct packed {
      logic [127:0]         ir;
      logic [3:0]           len;
      logic                 mem;
      logic [2:0]           reg_id;
      x86_isa_pkg::seg_id_t seg;
      logic                 op16;
      logic                 invalid;
   } row_t;

   logic              CLK;
   logic              rst;
   logic [127:0]      ir;
   logic              ir_valid;
   logic              ir_ready;
   pipe_pkg::ag_out_t ag_out;
   logic              ag_valid;
   logic              ag_ready;
   logic              wb_we;
   logic [2:0]        wb_id;
   logic [31:0]       wb_data;

   row_t        rows [NROWS];
   logic [31:0] gpr [8];
   int          exp_q [$];
   int          nrow;
   int          errors;
   int          sent;
   int          received;
   int          idx;
   int          lat;
   logic        rand_ready;
   logic [31:0] lcg_state;
   logic [31:0] exp_eip;
   logic [7:0]  exp_op;
   logic [31:0] exp_ea;
   logic [31:0] exp_imm;

   decode_pipeline DUT (
      .CLK(CLK), .rst(rst), .ir(ir), .ir_valid(ir_valid), .ir_ready(ir_ready),
      .ag_out(ag_out), .ag_valid(ag_valid), .ag_ready(ag_ready),
      .wb_we(wb_we), .wb_id(wb_id), .wb_data(wb_data)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   function automatic logic next_rand_bit();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[16];
   endfunction

   // Left-justify n instruction bytes into the window
   task automatic add_row(input logic [127:0] bytes, input int n, input logic [3:0] len,
                          input logic mem, input logic [2:0] reg_id,
                          input x86_isa_pkg::seg_id_t seg, input logic op16,
                          input logic invalid);
      rows[nrow] = '{bytes << (8 * (16 - n)), len, mem, reg_id, seg, op16, invalid};
      nrow++;
   endtask

   // Reference model for opcode, effective address and immediate
   function automatic void predict(input logic [127:0] w, output logic [7:0] opc,
                                   output logic [31:0] ea, output logic [31:0] imm);
      logic [7:0] b [16];
      int         p;
      int         i;
      int         isz;
      logic       op16;
      logic       use_base;
      logic [7:0] op;
      logic [1:0] md;
      logic [2:0] base;
      logic [7:0] s;
      for (int k = 0; k < 16; k++)
         b[k] = w[127 - 8 * k -: 8];
      p = 0;
      op16 = 1'b0;
      while (p < 3 && b[p] inside {8'h66, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65}) begin
         if (b[p] == 8'h66)
            op16 = 1'b1;
         p++;
      end
      op = b[p];
      opc = op;
      i = p + 1;
      ea = 32'd0;
      imm = 32'd0;
      isz = 0;
      if (op == 8'h81 || op[7:3] == 5'b10111)
         isz = op16 ? 2 : 4;
      else if (op == 8'h83)
         isz = 1;
      if (op inside {8'h01, 8'h03, 8'h89, 8'h8B, 8'h81, 8'h83}) begin
         md = b[i][7:6];
         base = b[i][2:0];
         use_base = (md != 2'b11);
         i++;
         if (md != 2'b11 && base == 3'b100) begin
            s = b[i];
            base = s[2:0];
            i++;
            if (s[5:3] != 3'b100)
               ea = gpr[s[5:3]] << s[7:6];
         end
         if (md == 2'b00 && base == 3'b101) begin
            use_base = 1'b0;
            ea = ea + {b[i + 3], b[i + 2], b[i + 1], b[i]};
            i += 4;
         end else if (md == 2'b01) begin
            ea = ea + {{24{b[i][7]}}, b[i]};
            i++;
         end else if (md == 2'b10) begin
            ea = ea + {b[i + 3], b[i + 2], b[i + 1], b[i]};
            i += 4;
         end
         if (use_base)
            ea = ea + gpr[base];
      end
      case (isz)
         1: imm = {{24{b[i][7]}}, b[i]};
         2: imm = {{16{b[i + 1][7]}}, b[i + 1], b[i]};
         4: imm = {b[i + 3], b[i + 2], b[i + 1], b[i]};
         default: imm = 32'd0;
      endcase
   endfunction

   task automatic check_val(input string what, input int row, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
      end
   endtask

   // Holds the word until the queue takes it
   task automatic send(input int r);
      ir <= rows[r].ir;
      ir_valid <= 1'b1;
      @(posedge CLK);
      while (!ir_ready)
         @(posedge CLK);
      exp_q.push_back(r);
      sent++;
   endtask

   always @(posedge CLK) begin
      if (rand_ready)
         ag_ready <= next_rand_bit();
   end

   // Output monitor and queue occupancy check
   always @(posedge CLK) begin
      if (!rst && !ir_ready && DUT.u_de_latch_fifo.count != `DE_FIFO_DEPTH) begin
         errors++;
         $display("Error at %0t: ir_ready low with queue not full", $time);
      end
      if (!rst && ag_valid && ag_ready) begin
         received++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: output with no instruction pending", $time);
         end else begin
            idx = exp_q.pop_front();
            predict(rows[idx].ir, exp_op, exp_ea, exp_imm);
            check_val("eip", idx, ag_out.eip, exp_eip);
            check_val("opcode", idx, 32'(ag_out.opcode), 32'(exp_op));
            check_val("length", idx, 32'(ag_out.length), 32'(rows[idx].len));
            check_val("mem", idx, 32'(ag_out.mem), 32'(rows[idx].mem));
            check_val("ea", idx, ag_out.ea, exp_ea);
            check_val("imm", idx, ag_out.imm, exp_imm);
            // No register field is defined for an invalid opcode
            if (!rows[idx].invalid)
               check_val("reg", idx, 32'(ag_out.reg_id), 32'(rows[idx].reg_id));
            check_val("seg", idx, 32'(ag_out.seg), 32'(rows[idx].seg));
            check_val("op16", idx, 32'(ag_out.op16), 32'(rows[idx].op16));
            check_val("invalid", idx, 32'(ag_out.invalid), 32'(rows[idx].invalid));
            exp_eip = exp_eip + 32'(rows[idx].len);
         end
      end
   end

   initial begin
      repeat ((NROWS + 1) * 20 + 100) @(posedge CLK);
      $display("Timeout: the run did not finish in time, %0d of %0d outputs seen",
               received, sent);
      $display("Errors: %0d", errors + 1);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      rst = 1'b1;
      ir = '0;
      ir_valid = 1'b0;
      ag_ready = 1'b0;
      wb_we = 1'b0;
      wb_id = 3'd0;
      wb_data = 32'd0;
      rand_ready = 1'b0;
      lcg_state = 32'd98;
      exp_eip = `RESET_EIP;
      errors = 0;
      sent = 0;
      received = 0;
      nrow = 0;
      // Register and immediate forms
      add_row(128'h01C8, 2, 4'd2, 1'b0, 3'd1, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h81C378563412, 6, 4'd6, 1'b0, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h83E8F0, 3, 4'd3, 1'b0, 3'd5, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'hBAEFBEADDE, 5, 4'd5, 1'b0, 3'd2, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      // Memory forms
      add_row(128'h8B03, 2, 4'd2, 1'b1, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h8B4E10, 3, 4'd3, 1'b1, 3'd1, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h899600010000, 6, 4'd6, 1'b1, 3'd2, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h8B048B, 3, 4'd3, 1'b1, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h8B4424FC, 4, 4'd4, 1'b1, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h8B0578563412, 6, 4'd6, 1'b1, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      add_row(128'h8B04CD00200000, 7, 4'd7, 1'b1, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      // Prefixes and an invalid opcode
      add_row(128'h6681C13412, 5, 4'd5, 1'b0, 3'd0, x86_isa_pkg::SEG_DS, 1'b1, 1'b0);
      add_row(128'h648B07, 3, 4'd3, 1'b1, 3'd0, x86_isa_pkg::SEG_FS, 1'b0, 1'b0);
      add_row(128'h2666B9FFFF, 5, 4'd5, 1'b0, 3'd1, x86_isa_pkg::SEG_ES, 1'b1, 1'b0);
      add_row(128'h0F0B, 2, 4'd1, 1'b0, 3'd0, x86_isa_pkg::SEG_DS, 1'b0, 1'b1);
      add_row(128'h368345087F, 5, 4'd5, 1'b1, 3'd0, x86_isa_pkg::SEG_SS, 1'b0, 1'b0);
      add_row(128'h03D8, 2, 4'd2, 1'b0, 3'd3, x86_isa_pkg::SEG_DS, 1'b0, 1'b0);
      for (int k = 0; k < 8; k++)
         gpr[k] = 32'h0001_0000 * (k + 1) + 32'h40 * k;

      repeat (8) @(posedge CLK);
      rst <= 1'b0;
      @(posedge CLK);
      if (!ir_ready || ag_valid) begin
         errors++;
         $display("Error at %0t: pipeline not idle after reset", $time);
      end
      for (int k = 0; k < 8; k++) begin
         wb_we <= 1'b1;
         wb_id <= 3'(k);
         wb_data <= gpr[k];
         @(posedge CLK);
      end
      wb_we <= 1'b0;

      // Single instruction into an empty pipeline
      ag_ready <= 1'b1;
      send(0);
      ir_valid <= 1'b0;
      lat = 0;
      do begin
         @(posedge CLK);
         lat++;
      end while (!ag_valid);
      if (lat != 2) begin
         errors++;
         $display("Error at %0t: latency %0d edges, expected 2", $time, lat);
      end
      @(posedge CLK);

      // Whole table under random back-pressure
      rand_ready <= 1'b1;
      for (int r = 0; r < NROWS; r++)
         send(r);
      ir_valid <= 1'b0;
      while (received < sent)
         @(posedge CLK);
      repeat (4) @(posedge CLK);
      if (received != sent) begin
         errors++;
         $display("Error at %0t: %0d outputs for %0d inputs", $time, received, sent);
      end
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/x86_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decode_stage1.sv
rtl/de_latch_fifo.sv
rtl/gpr_file.sv
rtl/decode_stage2.sv
rtl/decode_pipeline.sv
tb/decode_pipeline_assertions.sv
tb/decode_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module decode_pipeline_tb -Mdir obj_dir
out=$(./obj_dir/Vdecode_pipeline_tb)
echo "$out"
echo "$out" | grep -q "^PASS: all tests$"
